// ==== design/spim_cfg_pkg.sv ====
package spim_cfg_pkg;

  // ------------------------------
  // Lane modes
  // ------------------------------

  // Number of data lanes used in the receive phase
  // The encoding follows the mode field of the flash controller, 2'b11 was QDDR
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'b00,
    MODE_DUAL   = 2'b01,
    MODE_QUAD   = 2'b10
  } spim_mode_e;

  // ------------------------------
  // Bus widths
  // ------------------------------

  // Width of one word handed to the consumer
  localparam int SPIM_WORD_W = 32;

  // Width of the bit count of a read
  localparam int SPIM_CNT_W = 16;

  // Width of the command byte shifted out first
  localparam int SPIM_CMD_W = 8;

endpackage

// ==== design/spim_seq_pkg.sv ====
package spim_seq_pkg;

  // ------------------------------
  // Sequencer states
  // ------------------------------

  // Phases of one read, from chip select low to chip select high
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'b00,
    SEQ_CMD  = 2'b01,
    SEQ_RX   = 2'b10,
    SEQ_END  = 2'b11
  } spim_seq_state_e;

  // Receive block states, the two wait states hold a finished word
  typedef enum logic [1:0] {
    RX_IDLE      = 2'b00,
    RX_RECEIVE   = 2'b01,
    RX_WAIT_WORD = 2'b10,
    RX_WAIT_LAST = 2'b11
  } spim_rx_state_e;

endpackage

// ==== design/spim_seq_if.sv ====
`timescale 1ns/1ns

interface spim_seq_if import spim_cfg_pkg::*; ();

  // Command phase
  logic                  tx_en;
  logic                  tx_done;
  logic                  tx_clk_en;

  // Receive phase
  logic                  rx_en;
  logic [SPIM_CNT_W-1:0] rx_cnt;
  logic                  rx_cnt_upd;
  spim_mode_e            rx_mode;
  logic                  rx_done;
  logic                  rx_idle;
  logic                  rx_clk_en;

  // Serial clock edge strobes, one clk cycle wide
  logic                  sclk_rise;
  logic                  sclk_fall;

  modport ctrl (output tx_en, rx_en, rx_cnt, rx_cnt_upd, rx_mode,
                input  tx_done, rx_done, rx_idle);
  modport tx (input  tx_en, sclk_rise, sclk_fall,
              output tx_done, tx_clk_en);
  modport rx (input  rx_en, rx_cnt, rx_cnt_upd, rx_mode, sclk_rise,
              output rx_done, rx_idle, rx_clk_en);
  modport clkgen (input tx_clk_en, rx_clk_en, output sclk_rise, sclk_fall);

endinterface

// ==== design/spim_clkgen.sv ====
`timescale 1ns/1ns

module spim_clkgen #(
  parameter int unsigned CLK_DIV = 2
) (
  input  logic            clk,
  input  logic            rstn,
  spim_seq_if.clkgen      seq_if,
  output logic            sclk_o
);

  localparam int          CNT_W = $clog2(CLK_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

  logic [CNT_W-1:0] half_cnt;
  logic             clk_req;
  logic             run;

  // Either phase may ask for the serial clock
  assign clk_req = seq_if.tx_clk_en | seq_if.rx_clk_en;

  // A high half period always runs to its falling edge, so sclk_o never
  // stops high. A low half period without a request is dropped and restarts
  // from zero when the request comes back, which keeps the first low phase
  // at a full CLK_DIV cycles
  assign run = clk_req | sclk_o;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      half_cnt         <= '0;
      sclk_o           <= 1'b0;
      seq_if.sclk_rise <= 1'b0;
      seq_if.sclk_fall <= 1'b0;
    end else begin
      seq_if.sclk_rise <= 1'b0;
      seq_if.sclk_fall <= 1'b0;
      if (!run) begin
        half_cnt <= '0;
      end else if (half_cnt == CNT_LAST) begin
        // End of a half period, the strobe marks the cycle the pin changes
        half_cnt         <= '0;
        sclk_o           <= ~sclk_o;
        seq_if.sclk_rise <= ~sclk_o;
        seq_if.sclk_fall <= sclk_o;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // The command and receive phases never ask for the serial clock together
  a_req_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(seq_if.tx_clk_en && seq_if.rx_clk_en));

endmodule

// ==== design/spim_tx.sv ====
`timescale 1ns/1ns

module spim_tx import spim_cfg_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [SPIM_CMD_W-1:0] cmd_i,
  spim_seq_if.tx                seq_if,
  output logic                  sdo_o
);

  localparam int BIT_W = $clog2(SPIM_CMD_W);

  logic [SPIM_CMD_W-1:0] shift_q;
  logic [BIT_W-1:0]      bit_cnt;
  logic                  tx_en_q;
  logic                  tx_start;
  logic                  active_q;
  logic                  last_bit;

  // ------------------------------
  // Phase control
  // ------------------------------

  assign tx_start = seq_if.tx_en & ~tx_en_q;

  // The flash has sampled the last command bit on this rising edge
  assign last_bit = active_q & seq_if.sclk_rise & (bit_cnt == BIT_W'(SPIM_CMD_W - 1));

  assign seq_if.tx_done   = last_bit;
  // The request drops with the done pulse so no ninth period is started
  assign seq_if.tx_clk_en = active_q & ~last_bit;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      tx_en_q  <= 1'b0;
      active_q <= 1'b0;
      bit_cnt  <= '0;
      sdo_o    <= 1'b0;
    end else begin
      tx_en_q <= seq_if.tx_en;
      if (tx_start) begin
        // MSB goes out before the first rising edge
        active_q <= 1'b1;
        bit_cnt  <= '0;
        sdo_o    <= cmd_i[SPIM_CMD_W-1];
      end else if (last_bit) begin
        active_q <= 1'b0;
        bit_cnt  <= '0;
      end else if (active_q && seq_if.sclk_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
      end else if (active_q && seq_if.sclk_fall) begin
        sdo_o <= shift_q[SPIM_CMD_W-1];
      end else if (!seq_if.tx_en) begin
        sdo_o <= 1'b0;
      end
    end
  end

  // Remaining command bits, next bit always at the top
  always_ff @(posedge clk) begin
    if (tx_start) begin
      shift_q <= cmd_i << 1;
    end else if (active_q && seq_if.sclk_fall) begin
      shift_q <= shift_q << 1;
    end
  end

endmodule

// ==== design/spim_rx.sv ====
`timescale 1ns/1ns

module spim_rx import spim_cfg_pkg::*, spim_seq_pkg::*; #(
  parameter bit BIG_ENDIAN = 1'b0
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [3:0]             sdi_i,
  spim_seq_if.rx                 seq_if,
  output logic [SPIM_WORD_W-1:0] data_o,
  output logic                   data_valid_o,
  input  logic                   data_ready_i
);

  localparam int NBYTES = SPIM_WORD_W / 8;

  logic [SPIM_WORD_W-1:0] data_int;
  logic [SPIM_WORD_W-1:0] data_int_next;
  logic [SPIM_WORD_W-1:0] data_ordered;
  logic [SPIM_CNT_W-1:0]  counter;
  logic [SPIM_CNT_W-1:0]  counter_next;
  logic [SPIM_CNT_W-1:0]  counter_trgt;
  logic                   word_done;
  logic                   valid_d;
  spim_rx_state_e         rx_cs;
  spim_rx_state_e         rx_ns;

  // Counter holds shifts, not bits, so a word ends after 32/lanes shifts
  always_comb begin
    case (seq_if.rx_mode)
      MODE_QUAD: word_done = &counter[2:0];
      MODE_DUAL: word_done = &counter[3:0];
      default:   word_done = &counter[4:0];
    endcase
  end

  // ------------------------------
  // Next state and shift
  // ------------------------------

  always_comb begin
    rx_ns         = rx_cs;
    data_int_next = data_int;
    counter_next  = counter;
    valid_d       = 1'b0;
    case (rx_cs)
      RX_IDLE: begin
        if (seq_if.rx_en) rx_ns = RX_RECEIVE;
      end
      RX_RECEIVE: begin
        if (seq_if.sclk_rise) begin
          counter_next = counter + 1'b1;
          // Earlier bits move up, so the first bit ends at the word MSB
          case (seq_if.rx_mode)
            MODE_QUAD: data_int_next = {data_int[SPIM_WORD_W-5:0], sdi_i[3:0]};
            MODE_DUAL: data_int_next = {data_int[SPIM_WORD_W-3:0], sdi_i[1:0]};
            default:   data_int_next = {data_int[SPIM_WORD_W-2:0], sdi_i[1]};
          endcase
          if (seq_if.rx_done) begin
            counter_next = '0;
            if (data_ready_i) begin
              valid_d = 1'b1;
              rx_ns   = RX_IDLE;
            end else begin
              rx_ns = RX_WAIT_LAST;
            end
          end else if (word_done) begin
            // Consumer not ready, the serial clock stops until it is
            if (data_ready_i) valid_d = 1'b1;
            else              rx_ns   = RX_WAIT_WORD;
          end
        end
      end
      RX_WAIT_WORD: begin
        if (data_ready_i) begin
          valid_d = 1'b1;
          rx_ns   = RX_RECEIVE;
        end
      end
      RX_WAIT_LAST: begin
        if (data_ready_i) begin
          valid_d = 1'b1;
          rx_ns   = RX_IDLE;
        end
      end
      default: rx_ns = RX_IDLE;
    endcase
  end

  // First received byte lands in byte 0 unless big endian order is set
  always_comb begin
    for (int b = 0; b < NBYTES; b++) begin
      data_ordered[8*b +: 8] = data_int_next[SPIM_WORD_W-8*(b+1) +: 8];
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rx_cs            <= RX_IDLE;
      counter          <= '0;
      counter_trgt     <= '0;
      seq_if.rx_done   <= 1'b0;
      seq_if.rx_clk_en <= 1'b0;
      data_valid_o     <= 1'b0;
    end else begin
      rx_cs            <= rx_ns;
      counter          <= counter_next;
      data_valid_o     <= valid_d;
      seq_if.rx_clk_en <= (rx_ns == RX_RECEIVE);
      // Set one serial period ahead so the last shift sees it
      if (rx_cs == RX_RECEIVE && seq_if.sclk_rise) begin
        seq_if.rx_done <= (counter_next == counter_trgt - 1'b1);
      end
      // Target is kept in shifts of the selected lane count
      if (seq_if.rx_en && seq_if.rx_cnt_upd) begin
        case (seq_if.rx_mode)
          MODE_QUAD: counter_trgt <= seq_if.rx_cnt >> 2;
          MODE_DUAL: counter_trgt <= seq_if.rx_cnt >> 1;
          default:   counter_trgt <= seq_if.rx_cnt;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    data_int <= data_int_next;
    if (valid_d) data_o <= BIG_ENDIAN ? data_int_next : data_ordered;
  end

  assign seq_if.rx_idle = (rx_cs == RX_IDLE);

  // The sequencer holds the lane mode for the whole receive phase
  a_mode_stable: assert property (@(posedge clk) disable iff (!rstn)
    seq_if.rx_en && $past(seq_if.rx_en) |-> $stable(seq_if.rx_mode));

endmodule

// ==== design/spim_ctrl.sv ====
`timescale 1ns/1ns

module spim_ctrl import spim_cfg_pkg::*, spim_seq_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  req_i,
  input  spim_mode_e            mode_i,
  input  logic [SPIM_CNT_W-1:0] len_i,
  spim_seq_if.ctrl              seq_if,
  output logic                  csn_o,
  output logic                  busy_o
);

  spim_seq_state_e       state_q;
  spim_mode_e            mode_q;
  logic [SPIM_CNT_W-1:0] len_q;
  logic                  req_ok;

  // Requests only count in idle, a req_i while busy is dropped
  assign req_ok = req_i & (state_q == SEQ_IDLE);

  // Request fields for the receive block, held until the next request
  assign seq_if.rx_mode = mode_q;
  assign seq_if.rx_cnt  = len_q;

  always_ff @(posedge clk) begin
    if (req_ok) begin
      mode_q <= mode_i;
      len_q  <= len_i;
    end
  end

  // ------------------------------
  // Sequencer FSM
  // ------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q           <= SEQ_IDLE;
      csn_o             <= 1'b1;
      busy_o            <= 1'b0;
      seq_if.tx_en      <= 1'b0;
      seq_if.rx_en      <= 1'b0;
      seq_if.rx_cnt_upd <= 1'b0;
    end else begin
      seq_if.rx_cnt_upd <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          if (req_ok) begin
            // Chip select goes low together with the command start
            csn_o        <= 1'b0;
            busy_o       <= 1'b1;
            seq_if.tx_en <= 1'b1;
            state_q      <= SEQ_CMD;
          end
        end
        SEQ_CMD: begin
          if (seq_if.tx_done) begin
            seq_if.tx_en      <= 1'b0;
            seq_if.rx_en      <= 1'b1;
            seq_if.rx_cnt_upd <= 1'b1;
            state_q           <= SEQ_RX;
          end
        end
        SEQ_RX: begin
          if (seq_if.rx_done) begin
            seq_if.rx_en <= 1'b0;
            state_q      <= SEQ_END;
          end
        end
        SEQ_END: begin
          // Wait until the last word has left the receive block
          if (seq_if.rx_idle) begin
            csn_o   <= 1'b1;
            busy_o  <= 1'b0;
            state_q <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // The receive block only completes whole words
  a_len_words: assert property (@(posedge clk) disable iff (!rstn)
    req_ok |-> (len_i != '0) && (len_i[4:0] == 5'd0));

endmodule

// ==== design/spim_read_top.sv ====
`timescale 1ns/1ns

module spim_read_top import spim_cfg_pkg::*; #(
  parameter int unsigned CLK_DIV    = 2,
  parameter bit          BIG_ENDIAN = 1'b0
) (
  input  logic                   clk,
  input  logic                   rstn,
  // Request side
  input  logic                   req_i,
  input  logic [1:0]             mode_i,
  input  logic [SPIM_CMD_W-1:0]  cmd_i,
  input  logic [SPIM_CNT_W-1:0]  len_i,
  output logic                   busy_o,
  // Flash pins
  output logic                   csn_o,
  output logic                   sclk_o,
  output logic                   sdo_o,
  input  logic [3:0]             sdi_i,
  // Word output with back-pressure
  output logic [SPIM_WORD_W-1:0] data_o,
  output logic                   data_valid_o,
  input  logic                   data_ready_i
);

  spim_seq_if seq_if ();

  spim_ctrl i_spim_ctrl (
    .clk    (clk),
    .rstn   (rstn),
    .req_i  (req_i),
    .mode_i (spim_mode_e'(mode_i)),
    .len_i  (len_i),
    .seq_if (seq_if.ctrl),
    .csn_o  (csn_o),
    .busy_o (busy_o)
  );

  spim_clkgen #(.CLK_DIV(CLK_DIV)) i_spim_clkgen (
    .clk    (clk),
    .rstn   (rstn),
    .seq_if (seq_if.clkgen),
    .sclk_o (sclk_o)
  );

  spim_tx i_spim_tx (
    .clk    (clk),
    .rstn   (rstn),
    .cmd_i  (cmd_i),
    .seq_if (seq_if.tx),
    .sdo_o  (sdo_o)
  );

  spim_rx #(.BIG_ENDIAN(BIG_ENDIAN)) i_spim_rx (
    .clk          (clk),
    .rstn         (rstn),
    .sdi_i        (sdi_i),
    .seq_if       (seq_if.rx),
    .data_o       (data_o),
    .data_valid_o (data_valid_o),
    .data_ready_i (data_ready_i)
  );

endmodule

// ==== bench/spim_tb_clk.sv ====
`timescale 1ns/1ns

module spim_tb_clk #(
  parameter int unsigned PERIOD_NS = 4
) (
  output logic clk_o
);

  // Free running clock, starts low
  initial clk_o = 1'b0;
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== bench/spim_read_tb.sv ====
`timescale 1ns/1ns

module spim_read_tb import spim_cfg_pkg::*; ();

  localparam int unsigned CLK_DIV = 2;
  // Serial periods of all tests in single mode, plus stall and reset slack
  localparam int WORST_PERIODS = 40 + 40 + 56 + 40 + 6 * 136;
  localparam int WATCH_NS = 4 * (WORST_PERIODS * 2 * CLK_DIV * 4 + 4000);

  logic        clk;
  logic        rstn;
  logic        req_i;
  logic [1:0]  mode_i;
  logic [7:0]  cmd_i;
  logic [15:0] len_i;
  logic        busy_o;
  logic        csn_o;
  logic        sclk_o;
  logic        sdo_o;
  logic [3:0]  sdi_i;
  logic [31:0] data_o;
  logic        data_valid_o;
  logic        data_ready_i;

  // Flash model and scoreboard state
  logic [31:0] stream_q[$];
  int          total_bits;
  int          bit_pos;
  int          lanes;
  int          cmd_bits;
  logic [7:0]  cmd_seen;
  int          rise_cnt;
  int          data_rises;
  bit          stall_en;
  int          low_left;
  int          low_len;
  int          low_rises;
  int          errors;
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  string       cur_test;

  spim_tb_clk #(.PERIOD_NS(4)) i_spim_tb_clk (.clk_o(clk));

  spim_read_top #(.CLK_DIV(CLK_DIV), .BIG_ENDIAN(1'b0)) i_spim_read_top (
    .clk(clk), .rstn(rstn), .req_i(req_i), .mode_i(mode_i), .cmd_i(cmd_i),
    .len_i(len_i), .busy_o(busy_o), .csn_o(csn_o), .sclk_o(sclk_o), .sdo_o(sdo_o),
    .sdi_i(sdi_i), .data_o(data_o), .data_valid_o(data_valid_o),
    .data_ready_i(data_ready_i)
  );

  function automatic int lanes_of(input logic [1:0] mode);
    if (mode == MODE_QUAD) return 4;
    if (mode == MODE_DUAL) return 2;
    return 1;
  endfunction

  // Bit k of the stream, first bit is the MSB of the first word
  function automatic logic stream_bit(input int k);
    if (k >= total_bits) return 1'b0;
    return stream_q[k / 32][31 - (k % 32)];
  endfunction

  // First received byte lands in byte 0 of the word
  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  // --------------------------------
  // Flash model
  // --------------------------------

  // Command bits are captured where the flash samples them, later rises carry data
  always @(posedge sclk_o) begin
    rise_cnt++;
    if (!csn_o && cmd_bits < 8) begin
      cmd_seen = {cmd_seen[6:0], sdo_o};
      cmd_bits++;
    end else begin
      data_rises++;
    end
  end

  // Data changes shortly after the falling edge, highest lane carries the first bit
  always @(negedge sclk_o) begin
    if (!csn_o && cmd_bits == 8) begin
      #1;
      case (lanes)
        4: sdi_i = {stream_bit(bit_pos), stream_bit(bit_pos + 1),
                    stream_bit(bit_pos + 2), stream_bit(bit_pos + 3)};
        2: sdi_i = {2'b00, stream_bit(bit_pos), stream_bit(bit_pos + 1)};
        default: sdi_i = {2'b00, stream_bit(bit_pos), 1'b0};
      endcase
      bit_pos += lanes;
    end
  end

  // Consumer with random low stretches; ready stays high while a word is shown
  always @(posedge clk) begin
    #1;
    if (!stall_en) begin
      data_ready_i = 1'b1;
    end else if (low_left > 0 && !data_valid_o) begin
      if (data_ready_i) low_rises = data_rises;
      data_ready_i = 1'b0;
      low_left--;
      low_len++;
    end else begin
      // A long stretch spans more than one word time, so the clock must have stopped
      if (!data_ready_i && low_len > (32 / lanes + 2) * 2 * CLK_DIV) begin
        assert (data_rises - low_rises <= 32 / lanes + 1) else begin
          $display("ERROR %s: serial clock kept running while a word waited", cur_test);
          errors++;
          test_errs++;
        end
      end
      data_ready_i = 1'b1;
      low_len = 0;
      if ($urandom_range(0, 3) == 0) low_left = $urandom_range(40, 120);
    end
  end

  // --------------------------------
  // Read sequence
  // --------------------------------

  task automatic run_read(input string name, input logic [1:0] mode, input logic [7:0] cmd,
                          input int nwords, input bit stall, input bit extra_req);
    logic [31:0] got_q[$];
    int          cycle;
    int          extra;
    logic        ready_prev;
    cur_test  = name;
    test_errs = 0;
    stream_q.delete();
    for (int i = 0; i < nwords; i++) stream_q.push_back($urandom);
    total_bits = nwords * 32;
    bit_pos    = 0;
    cmd_bits   = 0;
    lanes      = lanes_of(mode);
    rise_cnt   = 0;
    low_left   = 0;
    stall_en   = stall;
    @(posedge clk);
    #1;
    mode_i = mode;
    cmd_i  = cmd;
    len_i  = 16'(total_bits);
    req_i  = 1'b1;
    @(posedge clk);
    #1;
    req_i = 1'b0;
    check_val("csn_o after req", 32'd0, csn_o);
    check_val("busy_o after req", 32'd1, busy_o);
    cycle      = 0;
    ready_prev = 1'b0;
    while (got_q.size() < nwords) begin
      @(posedge clk);
      // A word may only follow a cycle with ready high and must see ready itself
      if (data_valid_o) begin
        assert (ready_prev && data_ready_i) else begin
          $display("ERROR %s: data_valid_o raised without data_ready_i high", name);
          errors++;
          test_errs++;
        end
        got_q.push_back(data_o);
      end
      ready_prev = data_ready_i;
      cycle++;
      #1;
      req_i = 1'b0;
      // A second request in the middle of the read must be dropped
      if (extra_req && cycle == 20) begin
        mode_i = MODE_QUAD;
        len_i  = 16'd32;
        req_i  = 1'b1;
      end
    end
    check_val("csn_o after last word", 32'd1, csn_o);
    check_val("busy_o after last word", 32'd0, busy_o);
    extra = 0;
    repeat (40) begin
      @(posedge clk);
      if (data_valid_o) extra++;
    end
    check_val("extra words", 32'd0, extra);
    check_val("csn_o at end", 32'd1, csn_o);
    check_val("command", {24'd0, cmd}, {24'd0, cmd_seen});
    check_val("serial clock rises", 8 + total_bits / lanes, rise_cnt);
    for (int i = 0; i < nwords; i++) begin
      check_val($sformatf("word %0d", i), swap_bytes(stream_q[i]), got_q[i]);
    end
    stall_en = 1'b0;
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %s (%0d errors)", name, test_errs == 0 ? "ok" : "failed", test_errs);
  endtask

  task automatic check_reset_values();
    cur_test  = "reset";
    test_errs = 0;
    check_val("csn_o", 32'd1, csn_o);
    check_val("busy_o", 32'd0, busy_o);
    check_val("sclk_o", 32'd0, sclk_o);
    check_val("sdo_o", 32'd0, sdo_o);
    check_val("data_valid_o", 32'd0, data_valid_o);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test reset: %s (%0d errors)", test_errs == 0 ? "ok" : "failed", test_errs);
  endtask

  // --------------------------------
  // Watchdog
  // --------------------------------

  initial begin
    #(WATCH_NS);
    $display("Run stopped by watchdog after %0d ns, a read never completed", WATCH_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h60d6));
    rstn         = 1'b0;
    req_i        = 1'b0;
    mode_i       = MODE_SINGLE;
    cmd_i        = 8'h00;
    len_i        = 16'd0;
    sdi_i        = 4'h0;
    data_ready_i = 1'b1;
    stall_en     = 1'b0;
    lanes        = 1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    check_reset_values();
    run_read("single_32", MODE_SINGLE, 8'h3b, 1, 1'b0, 1'b0);
    run_read("quad_128", MODE_QUAD, 8'heb, 4, 1'b0, 1'b0);
    run_read("dual_96_stall", MODE_DUAL, 8'hbb, 3, 1'b1, 1'b0);
    run_read("req_while_busy", MODE_SINGLE, 8'h0b, 1, 1'b0, 1'b1);
    for (int i = 0; i < 6; i++) begin
      run_read($sformatf("random_%0d", i), 2'($urandom_range(0, 2)), 8'($urandom),
               $urandom_range(1, 4), 1'($urandom_range(0, 1)), 1'b0);
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== spim_read.f ====
design/spim_cfg_pkg.sv
design/spim_seq_pkg.sv
design/spim_seq_if.sv
design/spim_clkgen.sv
design/spim_tx.sv
design/spim_rx.sv
design/spim_ctrl.sv
design/spim_read_top.sv
bench/spim_tb_clk.sv
bench/spim_read_tb.sv

// ==== Bender.yml ====
package:
  name: spim_read

sources:
  - design/spim_cfg_pkg.sv
  - design/spim_seq_pkg.sv
  - design/spim_seq_if.sv
  - design/spim_clkgen.sv
  - design/spim_tx.sv
  - design/spim_rx.sv
  - design/spim_ctrl.sv
  - design/spim_read_top.sv
  - target: test
    files:
      - bench/spim_tb_clk.sv
      - bench/spim_read_tb.sv
